//--- hdl/alu_cfg.svh
/* widths, FIFO depth and Wishbone register offsets of the ALU coprocessor
   include this file wherever one of the macros is needed */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// operand and result width
`define ALU_W 32

// command FIFO depth and the width of its level count (0..depth)
`define ALU_FIFO_DEPTH 4
`define ALU_LVL_W 3

// sequence tag, wraps after 2**ALU_TAG_W commands
`define ALU_TAG_W 4

// byte offsets on wb_adr[3:0]
`define ALU_REG_SRC1 4'h0
`define ALU_REG_SRC2 4'h4
`define ALU_REG_CMD 4'h8
`define ALU_REG_STAT 4'hc

`endif

//--- hdl/alu_pkg.sv
/* shared types of the ALU coprocessor: op codes, second operand view,
   command and result records passed between front end, FIFO and execute stage */
`include "alu_cfg.svh"

package alu_pkg;

	// op codes in the numbering of the core's ALU control field
	// 14 and 15 are not defined and produce zero
	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_SLL   = 4'd2,
		OP_SLT   = 4'd3,
		OP_SLTU  = 4'd4,
		OP_XOR   = 4'd5,
		OP_SRL   = 4'd6,
		OP_SRA   = 4'd7,
		OP_OR    = 4'd8,
		OP_AND   = 4'd9,
		OP_PASS2 = 4'd10,
		OP_SRLI  = 4'd11,
		OP_SLLI  = 4'd12,
		OP_SRAI  = 4'd13
	} alu_op_e;

	// second operand, either the whole word or an immediate shift amount
	typedef union packed {
		logic [`ALU_W-1:0] word;
		struct packed {
			logic [`ALU_W-6:0] unused;
			logic [4:0]        shamt;
		} sh;
	} alu_src2_u;

	// one queued command, 72 bits
	typedef struct packed {
		logic [`ALU_TAG_W-1:0] tag;
		alu_op_e               op;
		logic [`ALU_W-1:0]     src1;
		alu_src2_u             src2;
	} alu_cmd_t;

	// one result beat, 37 bits
	typedef struct packed {
		logic [`ALU_TAG_W-1:0] tag;
		logic [`ALU_W-1:0]     data;
		logic                  zero;
	} alu_res_t;

endpackage

//--- hdl/alu_wb_front.sv
/* Wishbone classic slave in front of the command FIFO
   holds both operands, reports FIFO status and turns CMD writes into tagged commands */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_wb_front
	import alu_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	// Wishbone classic slave
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [3:0]            wb_adr,
	input  logic [`ALU_W-1:0]     wb_dat_w,
	output logic [`ALU_W-1:0]     wb_dat_r,
	output logic                  wb_ack,
	// command FIFO write side
	output logic                  push,
	output alu_cmd_t              push_cmd,
	input  logic                  full,
	input  logic [`ALU_LVL_W-1:0] level
);

	logic                  req;
	logic                  cmd_wr;
	logic                  do_ack;
	logic [`ALU_W-1:0]     rd_data;
	logic [`ALU_W-1:0]     src1_q;
	alu_src2_u             src2_q;
	logic [`ALU_TAG_W-1:0] tag_q;

	// ack is registered, so the cycle that shows ack must not count as a new request
	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign cmd_wr = req & wb_we & (wb_adr == `ALU_REG_CMD);

	// a CMD write waits here while the FIFO is full
	assign push = cmd_wr & ~full;
	// everything else is answered right away
	assign do_ack = req & (~cmd_wr | ~full);

	// read mux, unmapped offsets and CMD read as zero
	always_comb begin
		rd_data = '0;
		case (wb_adr)
			`ALU_REG_SRC1: rd_data = src1_q;
			`ALU_REG_SRC2: rd_data = src2_q.word;
			`ALU_REG_STAT: rd_data = {{(`ALU_W-`ALU_LVL_W-1){1'b0}}, full, level};
			default: rd_data = '0;
		endcase
	end

	// command built from the operands as they stand at the CMD write
	always_comb begin
		push_cmd.tag = tag_q;
		push_cmd.op = alu_op_e'(wb_dat_w[3:0]);
		push_cmd.src1 = src1_q;
		push_cmd.src2 = src2_q;
	end

	// ack pulse, operand registers and tag counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
			src1_q <= '0;
			src2_q <= '0;
			tag_q <= '0;
		end else begin
			wb_ack <= do_ack;
			if (do_ack && wb_we) begin
				// writes land on the same edge as the ack
				if (wb_adr == `ALU_REG_SRC1) begin
					src1_q <= wb_dat_w;
				end
				if (wb_adr == `ALU_REG_SRC2) begin
					src2_q.word <= wb_dat_w;
				end
			end
			// tag moves on only when a command really went in
			if (push) begin
				tag_q <= tag_q + 1'b1;
			end
		end
	end

	// read data only matters while ack is high
	always_ff @(posedge clk) begin
		if (do_ack) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

//--- hdl/alu_cmd_fifo.sv
/* show-ahead circular FIFO of command structs between bus front end and execute stage
   the head entry is visible on pop_cmd whenever pop_valid is high */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_cmd_fifo
	import alu_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	// write side
	input  logic                  push,
	input  alu_cmd_t              push_cmd,
	output logic                  full,
	output logic [`ALU_LVL_W-1:0] level,
	// read side
	input  logic                  pop,
	output logic                  pop_valid,
	output alu_cmd_t              pop_cmd
);

	localparam int PTR_W = $clog2(`ALU_FIFO_DEPTH);

	alu_cmd_t              mem [`ALU_FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [`ALU_LVL_W-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign full = (count == `ALU_LVL_W'(`ALU_FIFO_DEPTH));
	assign level = count;
	assign pop_valid = (count != '0);
	// head straight out of the array
	assign pop_cmd = mem[rd_ptr];

	// drop requests that cannot be served
	assign do_push = push & ~full;
	assign do_pop = pop & pop_valid;

	// pointers and level, a push and a pop on the same edge leave the level alone
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(`ALU_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`ALU_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

endmodule

//--- hdl/alu_exec.sv
/* execute stage: takes the FIFO head, computes result and zero flag
   and holds them in an output register that drains through a valid/ready port */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_exec
	import alu_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	// FIFO head
	input  logic     pop_valid,
	input  alu_cmd_t pop_cmd,
	output logic     pop,
	// result stream
	output logic     res_valid,
	output alu_res_t res,
	input  logic     res_ready
);

	logic [`ALU_W-1:0] src1;
	logic [`ALU_W-1:0] src2;
	logic [4:0]        shamt;
	logic [`ALU_W-1:0] data;
	logic              zero;

	assign src1 = pop_cmd.src1;
	// register shifts and logic ops see the whole word
	assign src2 = pop_cmd.src2.word;
	// immediate shifts only see the low five bits
	assign shamt = pop_cmd.src2.sh.shamt;

	// take the head when the output register is empty or drains this cycle
	assign pop = pop_valid & (~res_valid | res_ready);

	// result mux
	always_comb begin
		data = '0;
		case (pop_cmd.op)
			OP_ADD: data = src1 + src2;
			OP_SUB: data = src1 - src2;
			// full-word shift amount, 32 and up shifts everything out
			OP_SLL: data = src1 << src2;
			OP_SRL: data = src1 >> src2;
			// sign fill for large amounts
			OP_SRA: data = $signed(src1) >>> src2;
			OP_SLT: data = {{(`ALU_W-1){1'b0}}, $signed(src1) < $signed(src2)};
			OP_SLTU: data = {{(`ALU_W-1){1'b0}}, src1 < src2};
			OP_XOR: data = src1 ^ src2;
			OP_OR: data = src1 | src2;
			OP_AND: data = src1 & src2;
			OP_PASS2: data = src2;
			OP_SRLI: data = src1 >> shamt;
			OP_SLLI: data = src1 << shamt;
			OP_SRAI: data = $signed(src1) >>> shamt;
			// codes 14 and 15
			default: data = '0;
		endcase
	end

	// zero flag is taken on the final result, also for the compare codes
	assign zero = (data == '0);

	// valid flag of the output register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else if (pop) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	// payload only changes on a pop, so it stays put while stalled
	always_ff @(posedge clk) begin
		if (pop) begin
			res.tag <= pop_cmd.tag;
			res.data <= data;
			res.zero <= zero;
		end
	end

endmodule

//--- hdl/alu_unit_top.sv
/* top of the ALU coprocessor: Wishbone front end, command FIFO and execute stage
   commands enter through the bus and results leave on the valid/ready port in issue order */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_unit_top
	import alu_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	// Wishbone classic slave
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [3:0]        wb_adr,
	input  logic [`ALU_W-1:0] wb_dat_w,
	output logic [`ALU_W-1:0] wb_dat_r,
	output logic              wb_ack,
	// result stream
	output logic              res_valid,
	output alu_res_t          res,
	input  logic              res_ready
);

	// front end to FIFO
	logic                  push;
	alu_cmd_t              push_cmd;
	logic                  full;
	logic [`ALU_LVL_W-1:0] level;
	// FIFO to execute stage
	logic                  pop;
	logic                  pop_valid;
	alu_cmd_t              pop_cmd;

	alu_wb_front alu_wb_front_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.push     (push),
		.push_cmd (push_cmd),
		.full     (full),
		.level    (level)
	);

	alu_cmd_fifo alu_cmd_fifo_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_cmd  (push_cmd),
		.full      (full),
		.level     (level),
		.pop       (pop),
		.pop_valid (pop_valid),
		.pop_cmd   (pop_cmd)
	);

	alu_exec alu_exec_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.pop_valid (pop_valid),
		.pop_cmd   (pop_cmd),
		.pop       (pop),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready)
	);

endmodule

//--- test/alu_unit_chk.sv
/* protocol checker bound into the ALU coprocessor top
   watches the Wishbone ack and the result stream */
`timescale 1ns/1ps

module alu_unit_chk
	import alu_pkg::*;
(
	input logic     clk,
	input logic     arst_n,
	input logic     wb_cyc,
	input logic     wb_stb,
	input logic     wb_ack,
	input logic     res_valid,
	input alu_res_t res,
	input logic     res_ready
);

	// failed assertions, summed up at the end of the run
	int fails = 0;

	// ack only answers a live request
	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |-> (wb_cyc && wb_stb))
		else begin
			fails++;
			$error("wb_ack high without wb_cyc and wb_stb");
		end

	// registered ack is a single pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |=> !wb_ack)
		else begin
			fails++;
			$error("wb_ack held for more than one cycle");
		end

	// a stalled beat keeps valid and payload
	res_held: assert property (@(posedge clk) disable iff (!arst_n)
		(res_valid && !res_ready) |=> (res_valid && $stable(res)))
		else begin
			fails++;
			$error("result beat changed or dropped while stalled");
		end

	// outputs quiet during reset
	reset_quiet: assert property (@(posedge clk)
		!arst_n |-> (!res_valid && !wb_ack))
		else begin
			fails++;
			$error("res_valid or wb_ack high during reset");
		end

endmodule

bind alu_unit_top alu_unit_chk alu_unit_chk_i (
	.clk       (clk),
	.arst_n    (arst_n),
	.wb_cyc    (wb_cyc),
	.wb_stb    (wb_stb),
	.wb_ack    (wb_ack),
	.res_valid (res_valid),
	.res       (res),
	.res_ready (res_ready)
);

//--- test/alu_unit_tb.sv
/* testbench for the ALU coprocessor: issues commands over Wishbone with random operands
   and checks every result beat against a model of the op rules */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_unit_tb
	import alu_pkg::*;
();

	// 300 commands at up to 120 cycles each, plus the full-FIFO stall phase
	localparam int TIMEOUT_CYCLES = 40000;
	localparam int N_RANDOM = 192;
	localparam int SEED = 32'h1f52_8829;
	localparam int READY_RANDOM = 0;
	localparam int READY_LOW = 1;
	localparam int READY_HIGH = 2;
	// second operands around the limits of the shift range
	localparam logic [31:0] SRC2_EDGES [7] = '{32'd0, 32'd31, 32'd32, 32'd33, 32'd64,
		32'hffff_ffff, 32'h8000_0000};

	logic        clk = 1'b0;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        res_valid;
	alu_res_t    res;
	logic        res_ready = 1'b0;

	integer      seed = SEED;
	integer      ready_seed = ~SEED;
	int          ready_mode = READY_RANDOM;
	int          cycle_cnt = 0;
	// bus side counts belong to the main sequence, beat counts to the monitor
	int          bus_val_errs = 0;
	int          bus_other_errs = 0;
	int          beat_val_errs = 0;
	int          beat_other_errs = 0;
	logic [3:0]  tag_model = 4'd0;
	logic [31:0] src1_model = 32'd0;
	logic [31:0] src2_model = 32'd0;
	logic [31:0] rd_dummy;
	alu_res_t    exp_q [$];

	alu_unit_top alu_unit_top_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready)
	);

	always #20 clk = ~clk;

	// hard stop on a hung run
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles, %0d results still outstanding",
				cycle_cnt, exp_q.size());
			$display("Simulation failed");
			$finish;
		end
	end

	// arithmetic right shift through a sign-extended double word
	function automatic logic [31:0] shift_right_arith(logic [31:0] a, logic [4:0] amt);
		logic [63:0] ext;
		ext = {{32{a[31]}}, a} >> amt;
		return ext[31:0];
	endfunction

	// expected data straight from the op definitions
	function automatic logic [31:0] expect_data(logic [3:0] op, logic [31:0] a, logic [31:0] b);
		logic       big;
		logic [4:0] low;
		big = (b > 32'd31);
		low = b[4:0];
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a + ~b + 32'd1;
			OP_SLL: return big ? 32'd0 : a << low;
			// signs differ, so the negative one is smaller
			OP_SLT: return {31'd0, ((a[31] != b[31]) ? a[31] : (a < b))};
			OP_SLTU: return {31'd0, (a < b)};
			OP_XOR: return a ^ b;
			OP_SRL: return big ? 32'd0 : a >> low;
			OP_SRA: return big ? {32{a[31]}} : shift_right_arith(a, low);
			OP_OR: return a | b;
			OP_AND: return a & b;
			OP_PASS2: return b;
			OP_SRLI: return a >> low;
			OP_SLLI: return a << low;
			OP_SRAI: return shift_right_arith(a, low);
			default: return 32'd0;
		endcase
	endfunction

	// first operand, biased toward sign and carry corners
	function automatic logic [31:0] pick_src1();
		case (3'($random(seed)))
			3'd0: return 32'd0;
			3'd1: return 32'hffff_ffff;
			3'd2: return 32'h8000_0000;
			3'd3: return 32'h7fff_ffff;
			default: return $random(seed);
		endcase
	endfunction

	// second operand, biased toward shift amounts in and past the word
	function automatic logic [31:0] pick_src2();
		case (3'($random(seed)))
			3'd0: return 32'd0;
			3'd1: return 32'd31;
			3'd2: return 32'd32 + 32'(5'($random(seed)));
			3'd3: return 32'(5'($random(seed)));
			3'd4: return 32'hffff_ffff;
			3'd5: return 32'h8000_0000;
			default: return $random(seed);
		endcase
	endfunction

	task automatic bus_start(logic we, logic [3:0] adr, logic [31:0] dat);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
	endtask

	// request stays up over the edge that samples ack
	task automatic bus_finish(output logic [31:0] rdat);
		@(negedge clk);
		while (!wb_ack) begin
			@(negedge clk);
		end
		rdat = wb_dat_r;
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic write_reg(logic [3:0] adr, logic [31:0] dat);
		bus_start(1'b1, adr, dat);
		bus_finish(rd_dummy);
	endtask

	task automatic read_check(logic [3:0] adr, logic [31:0] exp, string name);
		logic [31:0] rd;
		bus_start(1'b0, adr, 32'd0);
		bus_finish(rd);
		assert (rd == exp) else begin
			bus_val_errs++;
			$display("CHECK FAILED %s: got %h, expected %h", name, rd, exp);
		end
	endtask

	task automatic load_operands(logic [31:0] a, logic [31:0] b);
		write_reg(`ALU_REG_SRC1, a);
		write_reg(`ALU_REG_SRC2, b);
		src1_model = a;
		src2_model = b;
	endtask

	// queue the beat the next CMD write must produce
	task automatic expect_cmd(logic [3:0] op);
		alu_res_t e;
		e.tag = tag_model;
		e.data = expect_data(op, src1_model, src2_model);
		e.zero = (e.data == 32'd0);
		exp_q.push_back(e);
		tag_model = tag_model + 4'd1;
	endtask

	task automatic issue_cmd(logic [31:0] a, logic [31:0] b, logic [3:0] op);
		load_operands(a, b);
		expect_cmd(op);
		write_reg(`ALU_REG_CMD, {28'd0, op});
	endtask

	// mode change lands between falling edges, away from the ready driver
	task automatic set_ready(int mode);
		@(posedge clk);
		ready_mode = mode;
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic check_beat();
		alu_res_t exp;
		assert (exp_q.size() != 0) else begin
			beat_other_errs++;
			$display("result beat with tag %h arrived with no command outstanding", res.tag);
		end
		if (exp_q.size() != 0) begin
			exp = exp_q.pop_front();
			assert (res.tag == exp.tag) else begin
				beat_val_errs++;
				$display("CHECK FAILED res.tag: got %h, expected %h", res.tag, exp.tag);
			end
			assert (res.data == exp.data) else begin
				beat_val_errs++;
				$display("CHECK FAILED res.data: got %h, expected %h", res.data, exp.data);
			end
			assert (res.zero == exp.zero) else begin
				beat_val_errs++;
				$display("CHECK FAILED res.zero: got %h, expected %h", res.zero, exp.zero);
			end
		end
	endtask

	// ready changes here, and a beat seen here moves on the next rising edge
	always @(negedge clk) begin
		if (!arst_n || ready_mode == READY_LOW) begin
			res_ready = 1'b0;
		end else if (ready_mode == READY_HIGH) begin
			res_ready = 1'b1;
		end else begin
			res_ready = 1'($random(ready_seed));
		end
		if (res_valid && res_ready) begin
			check_beat();
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [3:0]  op;
		int          val_errs;
		int          other_errs;
		int          chk_errs;
		arst_n = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 4'd0;
		wb_dat_w = 32'd0;
		@(negedge clk);
		arst_n = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		// reset state, then operand readback
		assert (!res_valid) else begin
			bus_other_errs++;
			$display("res_valid is high right after reset");
		end
		read_check(`ALU_REG_STAT, 32'd0, "wb_dat_r (STAT)");
		a = $random(seed);
		b = $random(seed);
		load_operands(a, b);
		read_check(`ALU_REG_SRC1, a, "wb_dat_r (SRC1)");
		read_check(`ALU_REG_SRC2, b, "wb_dat_r (SRC2)");

		// every defined code against each edge of the second operand
		for (int i = 0; i < 14; i++) begin
			for (int j = 0; j < 7; j++) begin
				issue_cmd(pick_src1(), SRC2_EDGES[j], 4'(i));
			end
		end
		// undefined codes come back as zero
		issue_cmd($random(seed), $random(seed), 4'd14);
		issue_cmd($random(seed), $random(seed), 4'd15);
		issue_cmd(32'hffff_ffff, 32'hffff_ffff, 4'd14);
		issue_cmd(32'h8000_0000, 32'd1, 4'd15);

		// fill output register and FIFO with ready low, the sixth write must stall
		set_ready(READY_HIGH);
		wait_drained();
		set_ready(READY_LOW);
		for (int n = 0; n < 5; n++) begin
			issue_cmd(pick_src1(), pick_src2(), 4'({$random(seed)} % 14));
		end
		read_check(`ALU_REG_STAT, 32'h0000_000c, "wb_dat_r (STAT)");
		load_operands(pick_src1(), pick_src2());
		op = 4'({$random(seed)} % 14);
		expect_cmd(op);
		bus_start(1'b1, `ALU_REG_CMD, {28'd0, op});
		repeat (8) begin
			@(negedge clk);
			assert (!wb_ack) else begin
				bus_other_errs++;
				$display("CMD write was acked while the FIFO was full");
			end
		end
		// the first command sits in the output register waiting for ready
		assert (res_valid) else begin
			bus_other_errs++;
			$display("no result held at the output while res_ready was held low");
		end
		set_ready(READY_HIGH);
		bus_finish(rd_dummy);
		wait_drained();

		// random traffic with a stalling sink, tags wrap many times
		set_ready(READY_RANDOM);
		for (int n = 0; n < N_RANDOM; n++) begin
			issue_cmd(pick_src1(), pick_src2(), 4'($random(seed)));
		end
		set_ready(READY_HIGH);
		wait_drained();
		repeat (4) @(negedge clk);

		val_errs = bus_val_errs + beat_val_errs;
		other_errs = bus_other_errs + beat_other_errs;
		chk_errs = alu_unit_top_i.alu_unit_chk_i.fails;
		$display("errors: %0d value mismatches, %0d other failures, %0d protocol assertions",
			val_errs, other_errs, chk_errs);
		if (val_errs + other_errs + chk_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/alu_wb_front.sv
hdl/alu_cmd_fifo.sv
hdl/alu_exec.sv
hdl/alu_unit_top.sv
test/alu_unit_chk.sv
test/alu_unit_tb.sv

//--- Makefile
# Verilator build and run of the ALU coprocessor testbench

TOP = alu_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# the run passes only when the output holds the pass line
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
